//--- asym_pkg.sv
`default_nettype none

package asym_pkg;

   // write side carries whole words, read side single bytes
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // bytes per word, also the number of RAM blocks
   localparam int RATIO = W_DATA_W / R_DATA_W;

   // select bits for one byte inside a word
   localparam int LSB_W = $clog2(RATIO);

   // byte addressing on the read side, word addressing on the write side
   localparam int MAXADDR_W = 6;
   localparam int MINADDR_W = MAXADDR_W - LSB_W;

   localparam int DEPTH_BYTES = 1 << MAXADDR_W;

   // fill count has to reach DEPTH_BYTES itself
   localparam int LEVEL_W = MAXADDR_W + 1;

   // above this level there is no room for another whole word
   localparam logic [LEVEL_W-1:0] FULL_LEVEL = LEVEL_W'(DEPTH_BYTES - RATIO);

endpackage

`default_nettype wire

//--- ram_2p.sv
`timescale 1ns/1ns
`default_nettype none

module ram_2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  wire              clk,
   input  wire              w_en,
   input  wire [ADDR_W-1:0] w_addr,
   input  wire [DATA_W-1:0] w_data,
   input  wire              r_en,
   input  wire [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] r_data
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   // write port
   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // read port, output only moves on an enabled read
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire

//--- ram_2p_asym.sv
`timescale 1ns/1ns
`default_nettype none

module ram_2p_asym (
   input  wire                            clk,
   // write port, one word per access
   input  wire                            w_en,
   input  wire [asym_pkg::MINADDR_W-1:0]  w_addr,
   input  wire [asym_pkg::W_DATA_W-1:0]   w_data,
   // read port, one byte per access
   input  wire                            r_en,
   input  wire [asym_pkg::MAXADDR_W-1:0]  r_addr,
   output logic [asym_pkg::R_DATA_W-1:0]  r_data
);

   // word part of the byte read address, shared by every block
   logic [asym_pkg::MINADDR_W-1:0] blk_r_addr;

   // byte select captured with the read, used one cycle later
   logic [asym_pkg::LSB_W-1:0] r_lsb_q;

   // outputs of the byte-wide blocks
   logic [asym_pkg::RATIO-1:0][asym_pkg::R_DATA_W-1:0] blk_r_data;

   assign blk_r_addr = r_addr[asym_pkg::MAXADDR_W-1:asym_pkg::LSB_W];

   // one block per byte lane
   // block i holds bits 8i+7..8i of every word
   for (genvar i = 0; i < asym_pkg::RATIO; i++) begin : g_blk
      ram_2p #(
         .DATA_W (asym_pkg::R_DATA_W),
         .ADDR_W (asym_pkg::MINADDR_W)
      ) i_ram (
         .clk    (clk),
         .w_en   (w_en),
         .w_addr (w_addr),
         .w_data (w_data[i*asym_pkg::R_DATA_W +: asym_pkg::R_DATA_W]),
         .r_en   (r_en),
         .r_addr (blk_r_addr),
         .r_data (blk_r_data[i])
      );
   end

   // lane select follows the block data, so capture it under the same enable
   // and the mux output then holds steady between reads
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_lsb_q <= r_addr[asym_pkg::LSB_W-1:0];
      end
   end

   // output byte mux
   assign r_data = blk_r_data[r_lsb_q];

endmodule

`default_nettype wire

//--- byte_fifo_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module byte_fifo_ctrl (
   input  wire                            clk,
   input  wire                            rst_n,
   // strobes from producer and consumer
   input  wire                            wr_en,
   input  wire                            rd_en,
   // status
   output logic                           full,
   output logic                           empty,
   output logic [asym_pkg::LEVEL_W-1:0]   level,
   output logic                           overflow,
   output logic                           underflow,
   output logic                           rd_valid,
   // RAM control
   output logic                           ram_w_en,
   output logic [asym_pkg::MINADDR_W-1:0] ram_w_addr,
   output logic                           ram_r_en,
   output logic [asym_pkg::MAXADDR_W-1:0] ram_r_addr
);

   // word write pointer and byte read pointer, msb is the wrap bit
   logic [asym_pkg::MINADDR_W:0] wr_ptr;
   logic [asym_pkg::MAXADDR_W:0] rd_ptr;

   // write pointer scaled to bytes
   logic [asym_pkg::LEVEL_W-1:0] wr_ptr_bytes;

   logic wr_accept;
   logic rd_accept;

   assign wr_ptr_bytes = {wr_ptr, {asym_pkg::LSB_W{1'b0}}};

   // difference wraps together with both pointers
   assign level = wr_ptr_bytes - rd_ptr;
   assign empty = (level == '0);
   assign full  = (level > asym_pkg::FULL_LEVEL);

   assign wr_accept = wr_en & ~full;
   assign rd_accept = rd_en & ~empty;

   assign ram_w_en   = wr_accept;
   assign ram_w_addr = wr_ptr[asym_pkg::MINADDR_W-1:0];
   assign ram_r_en   = rd_accept;
   assign ram_r_addr = rd_ptr[asym_pkg::MAXADDR_W-1:0];

   // pointers
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_accept) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_accept) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // RAM data arrives one cycle after the accepted read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_accept;
      end
   end

   // sticky error flags, only reset clears them
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         overflow  <= 1'b0;
         underflow <= 1'b0;
      end else begin
         if (wr_en && full) begin
            overflow <= 1'b1;
         end
         if (rd_en && empty) begin
            underflow <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- word_to_byte_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module word_to_byte_fifo (
   input  wire                           clk,
   input  wire                           rst_n,
   // producer side
   input  wire                           wr_en,
   input  wire [asym_pkg::W_DATA_W-1:0]  wr_data,
   output logic                          full,
   // consumer side
   input  wire                           rd_en,
   output logic [asym_pkg::R_DATA_W-1:0] rd_data,
   output logic                          rd_valid,
   output logic                          empty,
   output logic [asym_pkg::LEVEL_W-1:0]  level,
   output logic                          overflow,
   output logic                          underflow
);

   // controller to RAM
   logic                           ram_w_en;
   logic [asym_pkg::MINADDR_W-1:0] ram_w_addr;
   logic                           ram_r_en;
   logic [asym_pkg::MAXADDR_W-1:0] ram_r_addr;

   byte_fifo_ctrl i_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_en      (wr_en),
      .rd_en      (rd_en),
      .full       (full),
      .empty      (empty),
      .level      (level),
      .overflow   (overflow),
      .underflow  (underflow),
      .rd_valid   (rd_valid),
      .ram_w_en   (ram_w_en),
      .ram_w_addr (ram_w_addr),
      .ram_r_en   (ram_r_en),
      .ram_r_addr (ram_r_addr)
   );

   // word data goes straight into the storage
   ram_2p_asym i_ram (
      .clk    (clk),
      .w_en   (ram_w_en),
      .w_addr (ram_w_addr),
      .w_data (wr_data),
      .r_en   (ram_r_en),
      .r_addr (ram_r_addr),
      .r_data (rd_data)
   );

endmodule

`default_nettype wire

//--- tb_fifo_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fifo_checker (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire                           wr_en,
   input  wire [asym_pkg::W_DATA_W-1:0]  wr_data,
   input  wire                           rd_en,
   input  wire                           full,
   input  wire                           empty,
   input  wire [asym_pkg::LEVEL_W-1:0]   level,
   input  wire                           overflow,
   input  wire                           underflow,
   input  wire                           rd_valid,
   input  wire [asym_pkg::R_DATA_W-1:0]  rd_data,
   output int                            checks,
   output int                            errors
);

   // reference byte queue, oldest byte at the front
   logic [asym_pkg::R_DATA_W-1:0] model_q [$];

   logic                          exp_ovf;
   logic                          exp_udf;
   logic                          exp_valid;
   logic [asym_pkg::R_DATA_W-1:0] exp_data;
   logic                          m_full;
   logic                          m_empty;

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      end
   endtask

   initial begin
      checks    = 0;
      errors    = 0;
      exp_ovf   = 1'b0;
      exp_udf   = 1'b0;
      exp_valid = 1'b0;
      exp_data  = '0;
   end

   // outputs and strobes are both settled at the falling edge
   always @(negedge clk) begin
      int k;
      if (!rst_n) begin
         model_q.delete();
         exp_ovf   = 1'b0;
         exp_udf   = 1'b0;
         exp_valid = 1'b0;
      end else begin
         m_empty = (model_q.size() == 0);
         m_full  = (model_q.size() > (asym_pkg::DEPTH_BYTES - asym_pkg::RATIO));
         check_value("level", model_q.size(), 32'(level));
         check_value("full", 32'(m_full), 32'(full));
         check_value("empty", 32'(m_empty), 32'(empty));
         check_value("overflow", 32'(exp_ovf), 32'(overflow));
         check_value("underflow", 32'(exp_udf), 32'(underflow));
         check_value("rd_valid", 32'(exp_valid), 32'(rd_valid));
         if (exp_valid) begin
            check_value("rd_data", 32'(exp_data), 32'(rd_data));
         end
         // what the coming rising edge does
         if (wr_en && m_full) begin
            exp_ovf = 1'b1;
         end
         if (rd_en && m_empty) begin
            exp_udf = 1'b1;
         end
         exp_valid = rd_en && !m_empty;
         if (exp_valid) begin
            exp_data = model_q.pop_front();
         end
         if (wr_en && !m_full) begin
            // byte 0 of the word leaves first
            for (k = 0; k < asym_pkg::RATIO; k++) begin
               model_q.push_back(wr_data[k*asym_pkg::R_DATA_W +: asym_pkg::R_DATA_W]);
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- tb_word_to_byte_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module tb_word_to_byte_fifo;

   localparam logic [31:0] SEED = 32'h6730_db58;
   // right-shifting form of x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
   localparam int RESET_CYCLES = 5;
   localparam int TIMEOUT_MARGIN = 100;

   // where a row gets its strobes and data
   localparam logic [1:0] WORD_FIXED = 2'd0;
   localparam logic [1:0] WORD_RAND  = 2'd1;
   localparam logic [1:0] ALL_RAND   = 2'd2;

   typedef struct packed {
      int          test;
      int          reps;
      logic        wr;
      logic        rd;
      logic [1:0]  mode;
      logic [31:0] word;
   } step_t;

   logic                          clk;
   logic                          rst_n;
   logic                          wr_en;
   logic                          rd_en;
   logic [asym_pkg::W_DATA_W-1:0] wr_data;
   wire                           full;
   wire                           empty;
   wire                           rd_valid;
   wire                           overflow;
   wire                           underflow;
   wire [asym_pkg::R_DATA_W-1:0]  rd_data;
   wire [asym_pkg::LEVEL_W-1:0]   level;

   step_t       steps [$];
   logic [31:0] lfsr;
   int          cycles;
   int          max_cycles;
   int          checks;
   int          errors;

   word_to_byte_fifo i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .full      (full),
      .rd_en     (rd_en),
      .rd_data   (rd_data),
      .rd_valid  (rd_valid),
      .empty     (empty),
      .level     (level),
      .overflow  (overflow),
      .underflow (underflow)
   );

   tb_fifo_checker i_checker (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .rd_en     (rd_en),
      .full      (full),
      .empty     (empty),
      .level     (level),
      .overflow  (overflow),
      .underflow (underflow),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data),
      .checks    (checks),
      .errors    (errors)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ LFSR_TAPS;
      end
      return s >> 1;
   endfunction

   // one lfsr step per bit and the first bit ends up highest
   task automatic take_bits(input int n, output logic [31:0] v);
      int k;
      v = '0;
      for (k = 0; k < n; k++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic add_step(input int test, input int reps, input logic wr, input logic rd,
                           input logic [1:0] mode, input logic [31:0] word);
      step_t s;
      s.test = test;
      s.reps = reps;
      s.wr   = wr;
      s.rd   = rd;
      s.mode = mode;
      s.word = word;
      steps.push_back(s);
   endtask

   task automatic load_table();
      // idle after reset
      add_step(1, 3, 1'b0, 1'b0, WORD_FIXED, 32'h0);
      // one known word and four byte reads
      add_step(2, 1, 1'b1, 1'b0, WORD_FIXED, 32'h4433_2211);
      add_step(2, 4, 1'b0, 1'b1, WORD_FIXED, 32'h0);
      add_step(2, 2, 1'b0, 1'b0, WORD_FIXED, 32'h0);
      // fill and then write into a full buffer
      add_step(3, 16, 1'b1, 1'b0, WORD_RAND, 32'h0);
      add_step(3, 2, 1'b1, 1'b0, WORD_RAND, 32'h0);
      add_step(3, 2, 1'b0, 1'b0, WORD_FIXED, 32'h0);
      // drain with one read too many
      add_step(4, 64, 1'b0, 1'b1, WORD_FIXED, 32'h0);
      add_step(4, 1, 1'b0, 1'b1, WORD_FIXED, 32'h0);
      add_step(4, 2, 1'b0, 1'b0, WORD_FIXED, 32'h0);
      // 20 cycles of both reach level 61 before reading back to empty
      add_step(5, 20, 1'b1, 1'b1, WORD_RAND, 32'h0);
      add_step(5, 61, 1'b0, 1'b1, WORD_FIXED, 32'h0);
      add_step(5, 20, 1'b1, 1'b1, WORD_RAND, 32'h0);
      add_step(5, 61, 1'b0, 1'b1, WORD_FIXED, 32'h0);
      add_step(5, 20, 1'b1, 1'b1, WORD_RAND, 32'h0);
      add_step(5, 61, 1'b0, 1'b1, WORD_FIXED, 32'h0);
      add_step(5, 2, 1'b0, 1'b0, WORD_FIXED, 32'h0);
      // random traffic
      add_step(6, 300, 1'b0, 1'b0, ALL_RAND, 32'h0);
      add_step(6, 4, 1'b0, 1'b0, WORD_FIXED, 32'h0);
   endtask

   task automatic drive_step(input step_t s);
      logic [31:0] bits;
      case (s.mode)
         ALL_RAND: begin
            // writes one cycle in eight and reads one in two
            take_bits(3, bits);
            wr_en = &bits[2:0];
            take_bits(1, bits);
            rd_en = bits[0];
            take_bits(32, bits);
            wr_data = bits;
         end
         WORD_RAND: begin
            wr_en = s.wr;
            rd_en = s.rd;
            take_bits(32, bits);
            wr_data = bits;
         end
         default: begin
            wr_en = s.wr;
            rd_en = s.rd;
            wr_data = s.word;
         end
      endcase
   endtask

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > max_cycles) begin
         $display("timeout: stimulus still running after %0d cycles", cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   initial begin
      int i;
      int r;
      int prev_errors;
      rst_n   = 1'b0;
      wr_en   = 1'b0;
      rd_en   = 1'b0;
      wr_data = '0;
      lfsr    = SEED;
      cycles  = 0;
      load_table();
      max_cycles = RESET_CYCLES + TIMEOUT_MARGIN;
      foreach (steps[n]) begin
         max_cycles += steps[n].reps;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;
      prev_errors = 0;
      for (i = 0; i < steps.size(); i++) begin
         for (r = 0; r < steps[i].reps; r++) begin
            @(posedge clk);
            #2;
            drive_step(steps[i]);
         end
         if (i == steps.size() - 1 || steps[i+1].test != steps[i].test) begin
            $display("test %0d finished, %0d errors", steps[i].test, errors - prev_errors);
            prev_errors = errors;
         end
      end
      @(posedge clk);
      #2;
      wr_en = 1'b0;
      rd_en = 1'b0;
      // let the checker see the last reads
      repeat (3) @(posedge clk);
      #5;
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
asym_pkg.sv
ram_2p.sv
ram_2p_asym.sv
byte_fifo_ctrl.sv
word_to_byte_fifo.sv
tb_fifo_checker.sv
tb_word_to_byte_fifo.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing -f sim.f --top-module tb_word_to_byte_fifo -o tb_sim \
   && ./obj_dir/tb_sim | tee sim.log \
   || echo "build or run step failed"
grep -q "Simulation PASSED" sim.log \
   && echo "result: pass" \
   || { echo "result: fail"; exit 1; }
